/* hw/hough_pkg.sv */
package hough_pkg;

   ////////////////////////////////////////////////////////////
   // sizes and thresholds
   ////////////////////////////////////////////////////////////
   localparam int IMG_DIM         = 10;   // image side in pixels
   localparam int MAX_EDGES       = 32;   // edge store depth
   localparam int NUM_RAD_BINS    = 16;   // histogram bins, covers sqrt(162)
   localparam int MIN_RADIUS      = 1;
   localparam int MAX_RADIUS      = 6;
   localparam int X_VOTE_MIN      = 2;    // vote must be strictly above
   localparam int Y_VOTE_MIN      = 1;
   localparam int DEFAULT_CENT_LO = 4;    // fallback centre pair
   localparam int DEFAULT_CENT_HI = 5;

   ////////////////////////////////////////////////////////////
   // scalar types
   ////////////////////////////////////////////////////////////
   typedef logic [3:0] coord_t;      // one pixel coordinate
   typedef logic [9:0] row_t;        // bit j is column j
   typedef logic [9:0] cent_mask_t;  // one bit per candidate centre
   typedef logic [7:0] vote_t;       // midpoint accumulator
   typedef logic [5:0] edge_cnt_t;   // 0 to 32 points
   typedef logic [4:0] edge_idx_t;
   typedef logic [7:0] dist_sq_t;    // at most 9*9 + 9*9
   typedef logic [3:0] radius_t;
   typedef logic [5:0] rad_cnt_t;
   typedef logic [7:0] rad_mask_t;   // bit r set when radius r passes

   localparam coord_t LAST_COORD = coord_t'(IMG_DIM - 1);

   // minimum bin count per reported radius
   localparam rad_cnt_t RAD_THRESH [MIN_RADIUS:MAX_RADIUS] = '{
      6'd4, 6'd4, 6'd8, 6'd10, 6'd12, 6'd13
   };

   ////////////////////////////////////////////////////////////
   // bundles
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      coord_t x;  // column
      coord_t y;  // row
   } edge_pt_t;

   typedef struct packed {
      cent_mask_t x_mask;
      cent_mask_t y_mask;
   } cand_t;

   typedef struct packed {
      coord_t    x;
      coord_t    y;
      rad_mask_t rad_mask;
      logic      last;  // final centre of the frame
   } result_t;

   typedef enum logic [2:0] {
      LOAD, SCAN, PAIR_X, PAIR_Y, MASK, WAIT
   } voter_state_e;

   typedef enum logic [2:0] {
      IDLE, NEXT_CENT, FEED, DRAIN, JUDGE, EMIT
   } rad_state_e;

endpackage

/* hw/center_voter.sv */
`timescale 1ns/1ps

module center_voter (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_row_valid,
   input  hough_pkg::row_t      i_row,
   output logic                 o_row_ready,
   output hough_pkg::edge_pt_t  o_pt_wr,
   output logic                 o_pt_we,
   output hough_pkg::cand_t     o_cand,
   output logic                 o_cand_valid,
   input  logic                 i_frame_done
);

   hough_pkg::voter_state_e state;

   hough_pkg::row_t   img   [hough_pkg::IMG_DIM];
   hough_pkg::vote_t  x_acc [hough_pkg::IMG_DIM];
   hough_pkg::vote_t  y_acc [hough_pkg::IMG_DIM];

   hough_pkg::coord_t ln;  // row in LOAD/SCAN, line in the pair phases
   hough_pkg::coord_t pa;  // lower index of the pair
   hough_pkg::coord_t pb;  // upper index, or column in SCAN

   logic                  row_take;
   logic                  bit_a;
   logic                  bit_b;
   logic [4:0]            pair_sum;
   hough_pkg::coord_t     mid;
   logic                  pair_last;
   hough_pkg::cent_mask_t x_mask_c;
   hough_pkg::cent_mask_t y_mask_c;

   assign o_row_ready = (state == hough_pkg::LOAD);
   assign row_take    = i_row_valid && o_row_ready;

   // pixel pair under test, along a row for x votes and a column for y votes
   always_comb begin
      if (state == hough_pkg::PAIR_X) begin
         bit_a = img[ln][pa];
         bit_b = img[ln][pb];
      end else begin
         bit_a = img[pa][ln];
         bit_b = img[pb][ln];
      end
   end

   assign pair_sum  = {1'b0, pa} + {1'b0, pb};
   assign mid       = pair_sum[4:1];  // rounded down
   assign pair_last = (ln == hough_pkg::LAST_COORD) && (pb == hough_pkg::LAST_COORD) &&
                      (pa == hough_pkg::LAST_COORD - 4'd1);

   always_comb begin
      for (int c = 0; c < hough_pkg::IMG_DIM; c++) begin
         x_mask_c[c] = x_acc[c] > hough_pkg::vote_t'(hough_pkg::X_VOTE_MIN);
         y_mask_c[c] = y_acc[c] > hough_pkg::vote_t'(hough_pkg::Y_VOTE_MIN);
      end
      if (x_mask_c == '0) begin  // nothing voted, search the middle
         x_mask_c[hough_pkg::DEFAULT_CENT_LO] = 1'b1;
         x_mask_c[hough_pkg::DEFAULT_CENT_HI] = 1'b1;
      end
      if (y_mask_c == '0) begin
         y_mask_c[hough_pkg::DEFAULT_CENT_LO] = 1'b1;
         y_mask_c[hough_pkg::DEFAULT_CENT_HI] = 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // control
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state        <= hough_pkg::LOAD;
         ln           <= '0;
         pa           <= '0;
         pb           <= '0;
         o_pt_we      <= 1'b0;
         o_cand_valid <= 1'b0;
      end else begin
         o_pt_we      <= 1'b0;
         o_cand_valid <= 1'b0;
         case (state)
            hough_pkg::LOAD: if (row_take) begin
               ln <= ln + 1'b1;
               if (ln == hough_pkg::LAST_COORD) begin
                  state <= hough_pkg::SCAN;
                  ln    <= '0;
                  pb    <= '0;
               end
            end
            hough_pkg::SCAN: begin
               o_pt_we <= img[ln][pb];  // raster order
               pb      <= pb + 1'b1;
               if (pb == hough_pkg::LAST_COORD) begin
                  pb <= '0;
                  ln <= ln + 1'b1;
                  if (ln == hough_pkg::LAST_COORD) begin
                     state <= hough_pkg::PAIR_X;
                     ln    <= '0;
                     pa    <= '0;
                     pb    <= 4'd1;
                  end
               end
            end
            hough_pkg::PAIR_X, hough_pkg::PAIR_Y: begin
               if (pb != hough_pkg::LAST_COORD) begin
                  pb <= pb + 1'b1;
               end else if (pa == hough_pkg::LAST_COORD - 4'd1) begin
                  ln <= ln + 1'b1;  // next line
                  pa <= '0;
                  pb <= 4'd1;
               end else begin
                  pa <= pa + 1'b1;
                  pb <= pa + 4'd2;
               end
               if (pair_last) begin
                  state <= (state == hough_pkg::PAIR_X) ? hough_pkg::PAIR_Y : hough_pkg::MASK;
                  ln    <= '0;
                  pa    <= '0;
                  pb    <= 4'd1;
               end
            end
            hough_pkg::MASK: begin
               o_cand_valid <= 1'b1;
               state        <= hough_pkg::WAIT;
            end
            default: if (i_frame_done) begin  // WAIT
               state <= hough_pkg::LOAD;
               ln    <= '0;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // image, accumulators and output payload
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (row_take) img[ln] <= i_row;
      if (row_take && ln == hough_pkg::LAST_COORD) begin
         for (int c = 0; c < hough_pkg::IMG_DIM; c++) begin
            x_acc[c] <= '0;
            y_acc[c] <= '0;
         end
      end else if (bit_a && bit_b) begin
         if (state == hough_pkg::PAIR_X) x_acc[mid] <= x_acc[mid] + 1'b1;
         if (state == hough_pkg::PAIR_Y) y_acc[mid] <= y_acc[mid] + 1'b1;
      end
      if (state == hough_pkg::SCAN) begin
         o_pt_wr.x <= pb;
         o_pt_wr.y <= ln;
      end
      if (state == hough_pkg::MASK) begin
         o_cand.x_mask <= x_mask_c;
         o_cand.y_mask <= y_mask_c;
      end
   end

endmodule

/* hw/edge_point_store.sv */
`timescale 1ns/1ps

module edge_point_store (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  hough_pkg::edge_pt_t  i_pt_wr,
   input  logic                 i_pt_we,
   input  logic                 i_clear,
   input  hough_pkg::edge_idx_t i_rd_idx,
   output hough_pkg::edge_pt_t  o_rd_pt,
   output hough_pkg::edge_cnt_t o_count
);

   hough_pkg::edge_pt_t  mem [hough_pkg::MAX_EDGES];
   hough_pkg::edge_cnt_t count;
   logic                 wr_ok;

   // points past the store depth are dropped
   assign wr_ok   = i_pt_we && (count < hough_pkg::edge_cnt_t'(hough_pkg::MAX_EDGES));
   assign o_count = count;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         count <= '0;
      end else if (i_clear) begin
         count <= '0;  // frame finished
      end else if (wr_ok) begin
         count <= count + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_ok) mem[count[4:0]] <= i_pt_wr;
      o_rd_pt <= mem[i_rd_idx];  // one cycle read
   end

endmodule

/* hw/isqrt_pipe.sv */
`timescale 1ns/1ps

module isqrt_pipe (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_dsq_valid,
   input  hough_pkg::dist_sq_t i_dsq,
   output logic                o_root_valid,
   output hough_pkg::radius_t  o_root
);

   logic [3:0]          vld_q;
   logic [7:0]          rem_q  [4];
   hough_pkg::radius_t  root_q [4];
   hough_pkg::dist_sq_t dsq_q  [4];  // operand travels with the stage

   // one restoring step: bring down two bits, try root*4+1
   function automatic logic [11:0] sqrt_step(input logic [7:0]         rem,
                                             input hough_pkg::radius_t root,
                                             input logic [1:0]         pair);
      logic [7:0] rem_sh;
      logic [7:0] trial;
      rem_sh = {rem[5:0], pair};
      trial  = {2'b00, root, 2'b01};
      if (rem_sh >= trial) return {rem_sh - trial, root[2:0], 1'b1};
      return {rem_sh, root[2:0], 1'b0};
   endfunction

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) vld_q <= '0;
      else          vld_q <= {vld_q[2:0], i_dsq_valid};
   end

   ////////////////////////////////////////////////////////////
   // datapath, msb root bit first
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      {rem_q[0], root_q[0]} <= sqrt_step(8'd0, 4'd0, i_dsq[7:6]);
      dsq_q[0]              <= i_dsq;
      for (int s = 1; s < 4; s++) begin
         {rem_q[s], root_q[s]} <= sqrt_step(rem_q[s-1], root_q[s-1], dsq_q[s-1][7-2*s -: 2]);
         dsq_q[s]              <= dsq_q[s-1];
      end
   end

   assign o_root_valid = vld_q[3];
   assign o_root       = root_q[3];

endmodule

/* hw/radius_voter.sv */
`timescale 1ns/1ps

module radius_voter (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  hough_pkg::cand_t     i_cand,
   input  logic                 i_cand_valid,
   output hough_pkg::edge_idx_t o_rd_idx,
   input  hough_pkg::edge_pt_t  i_rd_pt,
   input  hough_pkg::edge_cnt_t i_count,
   output logic                 o_dsq_valid,
   output hough_pkg::dist_sq_t  o_dsq,
   input  logic                 i_root_valid,
   input  hough_pkg::radius_t   i_root,
   output logic                 o_res_valid,
   output hough_pkg::result_t   o_res,
   input  logic                 i_res_ready,
   output logic                 o_frame_done,
   output logic                 o_clear
);

   hough_pkg::rad_state_e state;

   hough_pkg::cent_mask_t x_mask;
   hough_pkg::cent_mask_t y_mask;
   hough_pkg::coord_t     cx;
   hough_pkg::coord_t     cy;
   hough_pkg::edge_cnt_t  n_pts;  // points in this frame
   hough_pkg::edge_cnt_t  idx;    // next point to read
   hough_pkg::edge_cnt_t  got;    // roots back for this centre
   logic                  rd_pend;
   logic                  done_q;
   hough_pkg::rad_cnt_t   hist [hough_pkg::NUM_RAD_BINS];
   hough_pkg::result_t    res_q;

   hough_pkg::coord_t     nxt_cx;
   hough_pkg::coord_t     nxt_cy;
   logic                  is_cent;
   logic                  is_last;
   hough_pkg::dist_sq_t   dx;
   hough_pkg::dist_sq_t   dy;
   hough_pkg::rad_mask_t  rad_mask;

   assign nxt_cy  = (cy == hough_pkg::LAST_COORD) ? 4'd0 : cy + 1'b1;
   assign nxt_cx  = (cy == hough_pkg::LAST_COORD) ? cx + 1'b1 : cx;
   assign is_cent = x_mask[cx] && y_mask[cy];
   // both masks are never empty, so any later x bit means another centre
   assign is_last = ((x_mask >> (5'(cx) + 5'd1)) == '0) &&
                    ((y_mask >> (5'(cy) + 5'd1)) == '0);

   ////////////////////////////////////////////////////////////
   // squared distance of the point read last cycle
   ////////////////////////////////////////////////////////////
   assign dx          = {4'd0, (cx > i_rd_pt.x) ? cx - i_rd_pt.x : i_rd_pt.x - cx};
   assign dy          = {4'd0, (cy > i_rd_pt.y) ? cy - i_rd_pt.y : i_rd_pt.y - cy};
   assign o_dsq       = dx * dx + dy * dy;
   assign o_dsq_valid = rd_pend;
   assign o_rd_idx    = idx[4:0];

   always_comb begin
      rad_mask = '0;
      for (int r = hough_pkg::MIN_RADIUS; r <= hough_pkg::MAX_RADIUS; r++) begin
         rad_mask[r] = hist[r] >= hough_pkg::RAD_THRESH[r];
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state   <= hough_pkg::IDLE;
         x_mask  <= '0;
         y_mask  <= '0;
         cx      <= '0;
         cy      <= '0;
         n_pts   <= '0;
         idx     <= '0;
         got     <= '0;
         rd_pend <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         rd_pend <= 1'b0;
         done_q  <= 1'b0;
         if (i_root_valid) got <= got + 1'b1;
         case (state)
            hough_pkg::IDLE: if (i_cand_valid) begin
               x_mask <= i_cand.x_mask;
               y_mask <= i_cand.y_mask;
               n_pts  <= i_count;  // store is full by now
               cx     <= '0;
               cy     <= '0;
               state  <= hough_pkg::NEXT_CENT;
            end
            hough_pkg::NEXT_CENT: begin
               if (is_cent) begin
                  idx   <= '0;
                  got   <= '0;
                  state <= hough_pkg::FEED;
               end else begin
                  cx <= nxt_cx;
                  cy <= nxt_cy;
               end
            end
            hough_pkg::FEED: begin
               if (idx == n_pts) begin
                  state <= hough_pkg::DRAIN;
               end else begin
                  rd_pend <= 1'b1;
                  idx     <= idx + 1'b1;
               end
            end
            hough_pkg::DRAIN: if (got == n_pts) state <= hough_pkg::JUDGE;
            hough_pkg::JUDGE: state <= hough_pkg::EMIT;
            default: if (i_res_ready) begin  // EMIT
               if (res_q.last) begin
                  done_q <= 1'b1;
                  state  <= hough_pkg::IDLE;
               end else begin
                  cx    <= nxt_cx;
                  cy    <= nxt_cy;
                  state <= hough_pkg::NEXT_CENT;
               end
            end
         endcase
      end
   end

   // histogram and result payload
   always_ff @(posedge clk) begin
      if (state == hough_pkg::NEXT_CENT && is_cent) begin
         for (int b = 0; b < hough_pkg::NUM_RAD_BINS; b++) hist[b] <= '0;
      end else if (i_root_valid) begin
         hist[i_root] <= hist[i_root] + 1'b1;
      end
      if (state == hough_pkg::JUDGE) begin
         res_q.x        <= cx;
         res_q.y        <= cy;
         res_q.rad_mask <= rad_mask;
         res_q.last     <= is_last;
      end
   end

   assign o_res_valid  = (state == hough_pkg::EMIT);
   assign o_res        = res_q;
   assign o_frame_done = done_q;
   assign o_clear      = done_q;  // store empties with the frame

endmodule

/* hw/hough_top.sv */
`timescale 1ns/1ps

module hough_top (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_row_valid,
   input  hough_pkg::row_t     i_row,
   output logic                o_row_ready,
   output logic                o_res_valid,
   output hough_pkg::result_t  o_res,
   input  logic                i_res_ready
);

   hough_pkg::edge_pt_t  pt_wr;
   logic                 pt_we;
   hough_pkg::cand_t     cand;
   logic                 cand_valid;
   logic                 frame_done;
   logic                 clear;
   hough_pkg::edge_idx_t rd_idx;
   hough_pkg::edge_pt_t  rd_pt;
   hough_pkg::edge_cnt_t count;
   logic                 dsq_valid;
   hough_pkg::dist_sq_t  dsq;
   logic                 root_valid;
   hough_pkg::radius_t   root;

   ////////////////////////////////////////////////////////////
   // producer, buffer, consumer
   ////////////////////////////////////////////////////////////
   center_voter u_center_voter (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_row_valid  (i_row_valid),
      .i_row        (i_row),
      .o_row_ready  (o_row_ready),
      .o_pt_wr      (pt_wr),
      .o_pt_we      (pt_we),
      .o_cand       (cand),
      .o_cand_valid (cand_valid),
      .i_frame_done (frame_done)
   );

   edge_point_store u_edge_point_store (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_pt_wr  (pt_wr),
      .i_pt_we  (pt_we),
      .i_clear  (clear),
      .i_rd_idx (rd_idx),
      .o_rd_pt  (rd_pt),
      .o_count  (count)
   );

   isqrt_pipe u_isqrt_pipe (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_dsq_valid  (dsq_valid),
      .i_dsq        (dsq),
      .o_root_valid (root_valid),
      .o_root       (root)
   );

   radius_voter u_radius_voter (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_cand       (cand),
      .i_cand_valid (cand_valid),
      .o_rd_idx     (rd_idx),
      .i_rd_pt      (rd_pt),
      .i_count      (count),
      .o_dsq_valid  (dsq_valid),
      .o_dsq        (dsq),
      .i_root_valid (root_valid),
      .i_root       (root),
      .o_res_valid  (o_res_valid),
      .o_res        (o_res),
      .i_res_ready  (i_res_ready),
      .o_frame_done (frame_done),
      .o_clear      (clear)
   );

endmodule

/* testbench/hough_sva.sv */
`timescale 1ns/1ps

module hough_sva (
   input logic               clk,
   input logic               i_rst_n,
   input logic               i_row_ready,
   input logic               i_res_valid,
   input hough_pkg::result_t i_res,
   input logic               i_res_ready
);

   // stalled result keeps valid and payload
   property res_held_p;
      @(posedge clk) disable iff (!i_rst_n)
         i_res_valid && !i_res_ready |=> i_res_valid && $stable(i_res);
   endproperty

   property row_closed_p;
      @(posedge clk) disable iff (!i_rst_n)
         i_res_valid |-> !i_row_ready;
   endproperty

   // more results of the frame still to come
   property row_closed_next_p;
      @(posedge clk) disable iff (!i_rst_n)
         i_res_valid && i_res_ready && !i_res.last |=> !i_row_ready;
   endproperty

   property valid_known_p;
      @(posedge clk) disable iff (!i_rst_n)
         !$isunknown(i_res_valid);
   endproperty

   a_res_held:   assert property (res_held_p)        else $error("o_res changed while stalled");
   a_row_closed: assert property (row_closed_p)      else $error("row ready high with result");
   a_row_next:   assert property (row_closed_next_p) else $error("row ready before last result");
   a_known:      assert property (valid_known_p)     else $error("o_res_valid unknown");

endmodule

bind hough_top hough_sva u_sva (
   .clk         (clk),
   .i_rst_n     (i_rst_n),
   .i_row_ready (o_row_ready),
   .i_res_valid (o_res_valid),
   .i_res       (o_res),
   .i_res_ready (i_res_ready)
);

/* testbench/hough_tb.sv */
`timescale 1ns/1ps

module hough_tb;

   localparam int NUM_FRAMES = 12;
   localparam int LAST_SPARSE = 7;  // frames 3..7 sparse, later ones dense

   logic               clk;
   logic               i_rst_n;
   logic               i_row_valid;
   hough_pkg::row_t    i_row;
   logic               o_row_ready;
   logic               o_res_valid;
   hough_pkg::result_t o_res;
   logic               i_res_ready;

   int                 seed;
   int                 n_got;
   hough_pkg::row_t    frames [NUM_FRAMES][hough_pkg::IMG_DIM];
   hough_pkg::result_t exp_q [$];
   hough_pkg::result_t want;

   hough_top u_dut (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_row_valid (i_row_valid),
      .i_row       (i_row),
      .o_row_ready (o_row_ready),
      .o_res_valid (o_res_valid),
      .o_res       (o_res),
      .i_res_ready (i_res_ready)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("ERROR: %s", why);
      $display("Verification failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
         abort_run("an output differs from the expected value");
      end
   endtask

   ////////////////////////////////////////////////////////////
   // stimulus frames
   ////////////////////////////////////////////////////////////
   task automatic make_frames();
      int pct;
      for (int f = 3; f < NUM_FRAMES; f++) begin
         if (f <= LAST_SPARSE) pct = 5 + int'($unsigned($random(seed)) % 25);
         else                  pct = 45 + int'($unsigned($random(seed)) % 45);
         for (int r = 0; r < hough_pkg::IMG_DIM; r++) begin
            for (int c = 0; c < hough_pkg::IMG_DIM; c++) begin
               frames[f][r][c] = ($unsigned($random(seed)) % 100) < pct;
            end
         end
      end
      for (int r = 0; r < hough_pkg::IMG_DIM; r++) begin
         frames[0][r] = '0;  // empty image
         frames[2][r] = '1;  // every pixel set, store overflows
      end
      // ring of radius 3 around column 4, row 4
      frames[1][0] = 10'h000;
      frames[1][1] = 10'h038;
      frames[1][2] = 10'h044;
      frames[1][3] = 10'h082;
      frames[1][4] = 10'h082;
      frames[1][5] = 10'h082;
      frames[1][6] = 10'h044;
      frames[1][7] = 10'h038;
      frames[1][8] = 10'h000;
      frames[1][9] = 10'h000;
   endtask

   ////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////
   task automatic build_expected(input int f);
      int                 x_acc [hough_pkg::IMG_DIM];
      int                 y_acc [hough_pkg::IMG_DIM];
      int                 hist [hough_pkg::NUM_RAD_BINS];
      int                 px [$];
      int                 py [$];
      logic [9:0]         xm;
      logic [9:0]         ym;
      int                 top_x;
      int                 top_y;
      int                 dsq;
      int                 rad;
      hough_pkg::result_t r;
      for (int c = 0; c < hough_pkg::IMG_DIM; c++) begin
         x_acc[c] = 0;
         y_acc[c] = 0;
      end
      // edge list in raster order, only the first MAX_EDGES kept
      for (int y = 0; y < hough_pkg::IMG_DIM; y++) begin
         for (int x = 0; x < hough_pkg::IMG_DIM; x++) begin
            if (frames[f][y][x] && px.size() < hough_pkg::MAX_EDGES) begin
               px.push_back(x);
               py.push_back(y);
            end
         end
      end
      for (int l = 0; l < hough_pkg::IMG_DIM; l++) begin
         for (int a = 0; a < hough_pkg::IMG_DIM - 1; a++) begin
            for (int b = a + 1; b < hough_pkg::IMG_DIM; b++) begin
               if (frames[f][l][a] && frames[f][l][b]) x_acc[(a + b) / 2]++;  // row pair
               if (frames[f][a][l] && frames[f][b][l]) y_acc[(a + b) / 2]++;  // column pair
            end
         end
      end
      for (int c = 0; c < hough_pkg::IMG_DIM; c++) begin
         xm[c] = x_acc[c] > hough_pkg::X_VOTE_MIN;
         ym[c] = y_acc[c] > hough_pkg::Y_VOTE_MIN;
      end
      if (xm == '0) begin
         xm[hough_pkg::DEFAULT_CENT_LO] = 1'b1;
         xm[hough_pkg::DEFAULT_CENT_HI] = 1'b1;
      end
      if (ym == '0) begin
         ym[hough_pkg::DEFAULT_CENT_LO] = 1'b1;
         ym[hough_pkg::DEFAULT_CENT_HI] = 1'b1;
      end
      top_x = 0;
      top_y = 0;
      for (int c = 0; c < hough_pkg::IMG_DIM; c++) begin
         if (xm[c]) top_x = c;
         if (ym[c]) top_y = c;
      end
      for (int x = 0; x < hough_pkg::IMG_DIM; x++) begin
         for (int y = 0; y < hough_pkg::IMG_DIM; y++) begin
            if (xm[x] && ym[y]) begin
               for (int b = 0; b < hough_pkg::NUM_RAD_BINS; b++) hist[b] = 0;
               for (int k = 0; k < px.size(); k++) begin
                  dsq = (x - px[k]) * (x - px[k]) + (y - py[k]) * (y - py[k]);
                  rad = 0;
                  while ((rad + 1) * (rad + 1) <= dsq) rad++;  // floor sqrt
                  hist[rad]++;
               end
               r.x        = 4'(x);
               r.y        = 4'(y);
               r.rad_mask = '0;
               for (int k = hough_pkg::MIN_RADIUS; k <= hough_pkg::MAX_RADIUS; k++) begin
                  r.rad_mask[k] = hist[k] >= int'(hough_pkg::RAD_THRESH[k]);
               end
               r.last = (x == top_x) && (y == top_y);
               exp_q.push_back(r);
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // drivers and monitor
   ////////////////////////////////////////////////////////////
   task automatic send_frame(input int f);
      for (int r = 0; r < hough_pkg::IMG_DIM; r++) begin
         i_row_valid <= 1'b1;
         i_row       <= frames[f][r];
         @(negedge clk);
         while (!o_row_ready) @(negedge clk);
         @(posedge clk);  // row taken on this edge
      end
      i_row_valid <= 1'b0;
      i_row       <= '0;
      @(negedge clk);
      check_val("o_row_ready", 32'(o_row_ready), 32'd0);
   endtask

   task automatic wait_results();
      int spin;
      spin = 0;
      while (exp_q.size() != 0) @(negedge clk);
      @(negedge clk);
      while (!o_row_ready && spin < 8) begin
         @(negedge clk);
         spin++;
      end
      check_val("o_row_ready", 32'(o_row_ready), 32'd1);  // input reopens
      @(posedge clk);
   endtask

   // random stalls on the result port
   initial begin
      forever begin
         @(posedge clk);
         if (i_rst_n) i_res_ready <= ($unsigned($random(seed)) % 4) != 0;
      end
   end

   always @(negedge clk) begin
      if (o_res_valid && i_res_ready) begin
         if (exp_q.size() == 0) begin
            abort_run("a result came out that the model did not expect");
         end else begin
            want = exp_q.pop_front();
            check_val("o_res.x", 32'(o_res.x), 32'(want.x));
            check_val("o_res.y", 32'(o_res.y), 32'(want.y));
            check_val("o_res.rad_mask", 32'(o_res.rad_mask), 32'(want.rad_mask));
            check_val("o_res.last", 32'(o_res.last), 32'(want.last));
            n_got++;
         end
      end
   end

   // watchdog, generous budget per frame
   initial begin
      repeat (16 + NUM_FRAMES * 20000) @(posedge clk);
      abort_run("timeout, the frames did not finish in time");
   end

   initial begin
      seed        = 51005;
      n_got       = 0;
      i_rst_n     = 1'b0;
      i_row_valid = 1'b0;
      i_row       = '0;
      i_res_ready = 1'b0;
      make_frames();
      repeat (16) @(posedge clk);
      i_rst_n <= 1'b1;
      @(posedge clk);
      for (int f = 0; f < NUM_FRAMES; f++) begin
         build_expected(f);
         send_frame(f);
         wait_results();
         $display("frame %0d done, %0d results so far", f, n_got);
      end
      $display("Verification passed");
      $finish;
   end

endmodule

/* sources.f */
hw/hough_pkg.sv
hw/center_voter.sv
hw/edge_point_store.sv
hw/isqrt_pipe.sv
hw/radius_voter.sv
hw/hough_top.sv
testbench/hough_sva.sv
testbench/hough_tb.sv

/* Makefile */
TOP = hough_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim

clean:
	rm -rf obj_dir
